/* cps2_video_mix.f */
+incdir+hw
hw/cps2_mix_pkg.sv
hw/cps2_mix_regs.sv
hw/cps2_layer_merge.sv
hw/cps2_colmix.sv
hw/cps2_palette.sv
hw/cps2_video_mix.sv
testbench/tb_cps2_video_mix.sv

/* hw/cps2_colmix.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cps2_mix_consts.svh"

module cps2_colmix (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   pxl_cen,
    input  wire cps2_mix_pkg::mix_pxl_t merged,
    input  wire cps2_mix_pkg::mix_pxl_t obj,
    input  wire logic                   obj_en,
    input  wire cps2_mix_pkg::reg16_t   lyr_prio,
    output cps2_mix_pkg::pxl_idx_t      mixed
);

    // object held back one edge to line up with merged.
    cps2_mix_pkg::mix_pxl_t obj_d;
    logic                   obj_en_d;

    // priority decision.
    cps2_mix_pkg::lyr_t scr_prio;
    logic               obj_top;
    logic               obj_vis;
    logic               scr_blank;
    logic               obj_sel;

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            obj_d <= obj;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            obj_en_d <= 1'b0;
        end else if (pxl_cen) begin
            obj_en_d <= obj_en;
        end
    end

    // nibble n of lyr_prio belongs to scroll n, only 3 bits count.
    always_comb begin
        case (merged.lyr)
            `CPS2_LYR_SCR1: scr_prio = lyr_prio[6:4];
            `CPS2_LYR_SCR2: scr_prio = lyr_prio[10:8];
            `CPS2_LYR_SCR3: scr_prio = lyr_prio[14:12];
            default:        scr_prio = 3'd7;
        endcase
    end

    // object lyr field carries its priority.
    assign obj_top   = obj_d.lyr > scr_prio;
    assign obj_vis   = obj_en_d && (obj_d.col[3:0] != `CPS2_TRANSP);
    assign scr_blank = merged.col[3:0] == `CPS2_TRANSP;
    assign obj_sel   = obj_vis && (obj_top || scr_blank);

    always_ff @(posedge clk) begin
        if (rst) begin
            mixed <= {3'd0, 5'd0, `CPS2_TRANSP};
        end else if (pxl_cen) begin
            mixed <= obj_sel ? {`CPS2_LYR_OBJ, obj_d.col}
                             : cps2_mix_pkg::pxl_idx_t'(merged);
        end
    end

    // object pens live in the lowest 512 palette entries.
    a_obj_bank: assert property (
        @(posedge clk) disable iff (rst) (pxl_cen && obj_sel) |=> (mixed[11:9] == 3'b000)
    ) else $error("object pixel left the object palette bank");

endmodule

`default_nettype wire

/* hw/cps2_layer_merge.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cps2_mix_consts.svh"

module cps2_layer_merge (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 pxl_cen,
    input  wire cps2_mix_pkg::col_t   scr1,
    input  wire cps2_mix_pkg::col_t   scr2,
    input  wire cps2_mix_pkg::col_t   scr3,
    input  wire cps2_mix_pkg::reg16_t layer_ctrl,
    output cps2_mix_pkg::mix_pxl_t    merged
);

    // pens indexed by slot code.
    // code 0 is an empty slot and always reads as transparent.
    cps2_mix_pkg::col_t scr_col [4];

    // per-code enable, code 0 never qualifies.
    logic [3:0] lyr_on;

    // search results.
    cps2_mix_pkg::mix_pxl_t pick;
    logic [1:0]             slot_code;
    logic                   found;

    assign scr_col[0] = {5'd0, `CPS2_TRANSP};
    assign scr_col[1] = scr1;
    assign scr_col[2] = scr2;
    assign scr_col[3] = scr3;

    // enables sit on layer_ctrl[3:1].
    assign lyr_on = {layer_ctrl[3:1], 1'b0};

    // walk the slots from the top one (bits 13:12) down to slot 0 (bits 7:6).
    // the first enabled layer with a visible pen wins.
    always_comb begin
        pick.lyr  = '0;
        pick.col  = scr_col[0];
        found     = 1'b0;
        slot_code = '0;
        for (int s = 3; s >= 0; s--) begin
            slot_code = layer_ctrl[6 + 2*s +: 2];
            if (!found && lyr_on[slot_code]
                    && (scr_col[slot_code][3:0] != `CPS2_TRANSP)) begin
                found    = 1'b1;
                pick.lyr = {1'b0, slot_code};
                pick.col = scr_col[slot_code];
            end
        end
    end

    // nothing found leaves code 0 with a transparent pen.
    // code 0 later maps to scroll priority 7.
    always_ff @(posedge clk) begin
        if (rst) begin
            merged.lyr <= '0;
            merged.col <= {5'd0, `CPS2_TRANSP};
        end else if (pxl_cen) begin
            merged <= pick;
        end
    end

    // only scroll codes or the empty code may leave this stage.
    a_lyr_range: assert property (
        @(posedge clk) disable iff (rst) merged.lyr <= `CPS2_LYR_SCR3
    ) else $error("merged layer code out of range");

endmodule

`default_nettype wire

/* hw/cps2_mix_consts.svh */
`ifndef CPS2_MIX_CONSTS_SVH
`define CPS2_MIX_CONSTS_SVH

// field widths shared by the mixing pipeline.
`define CPS2_COL_W   9
`define CPS2_LYR_W   3
`define CPS2_IDX_W   12
`define CPS2_DATA_W  16

// low nibble of a pen that shows nothing.
`define CPS2_TRANSP  4'hf

// layer codes carried in the top bits of a pixel index.
`define CPS2_LYR_OBJ   3'd0
`define CPS2_LYR_SCR1  3'd1
`define CPS2_LYR_SCR2  3'd2
`define CPS2_LYR_SCR3  3'd3

// register select codes, compared against addr[3:1].
`define CPS2_REG_LAYER 3'd1
`define CPS2_REG_PRIO  3'd2

// palette word address width, 4096 entries.
`define CPS2_PAL_AW  12

`endif

/* hw/cps2_mix_pkg.sv */
`default_nettype none

`include "cps2_mix_consts.svh"

package cps2_mix_pkg;

    // color index inside one layer, palette and pen.
    typedef logic [`CPS2_COL_W-1:0] col_t;

    // layer code, or object priority on object pixels.
    typedef logic [`CPS2_LYR_W-1:0] lyr_t;

    // full palette index.
    typedef logic [`CPS2_IDX_W-1:0] pxl_idx_t;

    // cpu data word.
    typedef logic [`CPS2_DATA_W-1:0] reg16_t;

    // pixel passed between stages, packs like pxl_idx_t.
    typedef struct packed {
        lyr_t lyr;
        col_t col;
    } mix_pxl_t;

    // one cpu write cycle.
    // dsn is active low, dsn[1] strobes the upper byte.
    typedef struct packed {
        reg16_t      data;
        logic [12:1] addr;
        logic [1:0]  dsn;
    } cpu_wr_t;

    // final color, 8 bits per channel.
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

endpackage

`default_nettype wire

/* hw/cps2_mix_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cps2_mix_consts.svh"

module cps2_mix_regs (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  regs_cs,
    input  wire cps2_mix_pkg::cpu_wr_t wr,
    output cps2_mix_pkg::reg16_t       layer_ctrl,
    output cps2_mix_pkg::reg16_t       lyr_prio
);

    // merge a write into an old value, one byte per low dsn bit.
    function automatic cps2_mix_pkg::reg16_t byte_merge(
        input cps2_mix_pkg::reg16_t  old_val,
        input cps2_mix_pkg::cpu_wr_t w
    );
        cps2_mix_pkg::reg16_t res;
        res = old_val;
        if (!w.dsn[1]) begin
            res[15:8] = w.data[15:8];
        end
        if (!w.dsn[0]) begin
            res[7:0] = w.data[7:0];
        end
        return res;
    endfunction

    // register select decode.
    logic sel_layer;
    logic sel_prio;

    assign sel_layer = regs_cs && (wr.addr[3:1] == `CPS2_REG_LAYER);
    assign sel_prio  = regs_cs && (wr.addr[3:1] == `CPS2_REG_PRIO);

    // writes land on the same edge the chip select is seen.
    always_ff @(posedge clk) begin
        if (rst) begin
            layer_ctrl <= '0;
            lyr_prio   <= '0;
        end else begin
            if (sel_layer) begin
                layer_ctrl <= byte_merge(layer_ctrl, wr);
            end
            if (sel_prio) begin
                lyr_prio <= byte_merge(lyr_prio, wr);
            end
        end
    end

    // a select with no byte strobe means the bus went wrong upstream.
    a_no_empty_write: assert property (
        @(posedge clk) disable iff (rst) !(regs_cs && (&wr.dsn))
    ) else $error("register write with both byte strobes off");

endmodule

`default_nettype wire

/* hw/cps2_palette.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cps2_mix_consts.svh"

module cps2_palette (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   pxl_cen,
    input  wire logic                   pal_cs,
    input  wire logic                   regs_cs,
    input  wire cps2_mix_pkg::cpu_wr_t  wr,
    input  wire cps2_mix_pkg::pxl_idx_t mixed,
    output cps2_mix_pkg::rgb_t          rgb
);

    localparam int PAL_DEPTH = 1 << `CPS2_PAL_AW;

    // palette word: bright[15:12] red[11:8] green[7:4] blue[3:0].
    cps2_mix_pkg::reg16_t pal_ram [PAL_DEPTH];

    // word read for the current index.
    cps2_mix_pkg::reg16_t pal_q;

    // channel times (bright + 1).
    // 15 * 16 = 240 is the worst case, so 8 bits are enough.
    function automatic logic [7:0] scale(
        input logic [3:0] chan,
        input logic [3:0] bright
    );
        logic [7:0] mult;
        mult = {4'd0, bright} + 8'd1;
        return {4'd0, chan} * mult;
    endfunction

    // cpu side, byte lanes written on a low dsn bit.
    always_ff @(posedge clk) begin
        if (pal_cs) begin
            if (!wr.dsn[1]) begin
                pal_ram[wr.addr][15:8] <= wr.data[15:8];
            end
            if (!wr.dsn[0]) begin
                pal_ram[wr.addr][7:0] <= wr.data[7:0];
            end
        end
    end

    // pixel side, synchronous read first.
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_q <= pal_ram[mixed];
        end
    end

    // scaling on the following pixel edge.
    always_ff @(posedge clk) begin
        if (rst) begin
            rgb <= '0;
        end else if (pxl_cen) begin
            rgb.r <= scale(pal_q[11:8], pal_q[15:12]);
            rgb.g <= scale(pal_q[7:4], pal_q[15:12]);
            rgb.b <= scale(pal_q[3:0], pal_q[15:12]);
        end
    end

    // the two cpu windows decode from the same bus and must not overlap.
    a_cs_excl: assert property (
        @(posedge clk) disable iff (rst) !(pal_cs && regs_cs)
    ) else $error("palette and register selects both active");

endmodule

`default_nettype wire

/* hw/cps2_video_mix.sv */
`timescale 1ns/10ps
`default_nettype none

module cps2_video_mix (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   pxl_cen,
    input  wire logic                   regs_cs,
    input  wire logic                   pal_cs,
    input  wire cps2_mix_pkg::cpu_wr_t  wr,
    input  wire cps2_mix_pkg::col_t     scr1,
    input  wire cps2_mix_pkg::col_t     scr2,
    input  wire cps2_mix_pkg::col_t     scr3,
    input  wire cps2_mix_pkg::mix_pxl_t obj,
    input  wire logic                   obj_en,
    output cps2_mix_pkg::rgb_t          rgb
);

    // cpu registers.
    cps2_mix_pkg::reg16_t layer_ctrl;
    cps2_mix_pkg::reg16_t lyr_prio;

    // stage outputs.
    cps2_mix_pkg::mix_pxl_t merged;
    cps2_mix_pkg::pxl_idx_t mixed;

    cps2_mix_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .regs_cs    (regs_cs),
        .wr         (wr),
        .layer_ctrl (layer_ctrl),
        .lyr_prio   (lyr_prio)
    );

    // stage 1, scroll layers only.
    cps2_layer_merge u_merge (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .scr1       (scr1),
        .scr2       (scr2),
        .scr3       (scr3),
        .layer_ctrl (layer_ctrl),
        .merged     (merged)
    );

    // stage 2, object against scroll.
    cps2_colmix u_colmix (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .merged   (merged),
        .obj      (obj),
        .obj_en   (obj_en),
        .lyr_prio (lyr_prio),
        .mixed    (mixed)
    );

    // stage 3, two edges, ram read then scaling.
    cps2_palette u_palette (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .pal_cs  (pal_cs),
        .regs_cs (regs_cs),
        .wr      (wr),
        .mixed   (mixed),
        .rgb     (rgb)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cps2_video_mix testbench with verilator.
set -e

cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert \
    --top-module tb_cps2_video_mix \
    --Mdir obj_dir -o tb_sim \
    -f cps2_video_mix.f

# keep the whole simulator output for the search below.
./obj_dir/tb_sim > "$log" 2>&1 || true
cat "$log"

if grep -q "FAIL: see errors above" "$log"; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "PASS: all tests" "$log"; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

/* testbench/tb_cps2_video_mix.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cps2_mix_consts.svh"

module tb_cps2_video_mix;

    // one table row, register values, pixels and the hand-worked result.
    typedef struct packed {
        cps2_mix_pkg::reg16_t   lctl;
        cps2_mix_pkg::reg16_t   prio;
        logic [1:0]             prio_dsn;
        cps2_mix_pkg::col_t     s1;
        cps2_mix_pkg::col_t     s2;
        cps2_mix_pkg::col_t     s3;
        cps2_mix_pkg::mix_pxl_t obj;
        logic                   obj_en;
        cps2_mix_pkg::pxl_idx_t exp_idx;
    } vec_t;

    // scroll pens, visible and with a transparent low nibble.
    localparam cps2_mix_pkg::col_t p1 = 9'h121;
    localparam cps2_mix_pkg::col_t p2 = 9'h142;
    localparam cps2_mix_pkg::col_t p3 = 9'h163;
    localparam cps2_mix_pkg::col_t t1 = 9'h12f;
    localparam cps2_mix_pkg::col_t t2 = 9'h14f;
    localparam cps2_mix_pkg::col_t t3 = 9'h16f;
    // object pens.
    localparam cps2_mix_pkg::col_t op = 9'h05a;
    localparam cps2_mix_pkg::col_t ot = 9'h05f;
    // pen shown when nothing is visible.
    localparam cps2_mix_pkg::col_t blank = {5'd0, `CPS2_TRANSP};

    logic                   clk;
    logic                   rst;
    logic                   pxl_cen;
    logic                   regs_cs;
    logic                   pal_cs;
    cps2_mix_pkg::cpu_wr_t  wr;
    cps2_mix_pkg::col_t     scr1;
    cps2_mix_pkg::col_t     scr2;
    cps2_mix_pkg::col_t     scr3;
    cps2_mix_pkg::mix_pxl_t obj;
    logic                   obj_en;
    cps2_mix_pkg::rgb_t     rgb;

    logic [31:0]            lfsr;
    cps2_mix_pkg::reg16_t   pal_copy [4096];
    vec_t                   vecs [$];

    // pixels in flight, one entry per pixel enable edge.
    logic                   hist_vld [$];
    cps2_mix_pkg::pxl_idx_t hist_idx [$];
    int                     hist_row [$];

    cps2_video_mix dut (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .regs_cs (regs_cs),
        .pal_cs  (pal_cs),
        .wr      (wr),
        .scr1    (scr1),
        .scr2    (scr2),
        .scr3    (scr3),
        .obj     (obj),
        .obj_en  (obj_en),
        .rgb     (rgb)
    );

    always #2 clk = ~clk;

    // pixel enable on every second clock.
    always begin
        @(posedge clk);
        #0.5;
        pxl_cen = ~pxl_cen;
    end

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic rand_word(output cps2_mix_pkg::reg16_t val);
        val = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[14:0], lfsr[0]};
        end
    endtask

    // each channel times (brightness + 1).
    function automatic cps2_mix_pkg::rgb_t expect_rgb(input cps2_mix_pkg::reg16_t w);
        cps2_mix_pkg::rgb_t res;
        int gain;
        gain  = int'(w[15:12]) + 1;
        res.r = 8'(int'(w[11:8]) * gain);
        res.g = 8'(int'(w[7:4]) * gain);
        res.b = 8'(int'(w[3:0]) * gain);
        return res;
    endfunction

    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_rgb(input cps2_mix_pkg::rgb_t got, input cps2_mix_pkg::rgb_t exp,
                             input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_idx(input cps2_mix_pkg::pxl_idx_t got,
                             input cps2_mix_pkg::pxl_idx_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    // returns on the first clock edge that has pxl_cen high.
    task automatic wait_cen_edge();
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 64) begin
            @(posedge clk);
            cycles++;
            seen = pxl_cen;
        end
        if (!seen) begin
            $display("no pixel clock enable within 64 clock cycles at %0t", $time);
            stop_on_error();
        end
    endtask

    // single-cycle chip select write.
    task automatic cpu_write(input logic to_pal, input logic [12:1] addr,
                             input cps2_mix_pkg::reg16_t data, input logic [1:0] dsn);
        wr.data = data;
        wr.addr = addr;
        wr.dsn  = dsn;
        regs_cs = !to_pal;
        pal_cs  = to_pal;
        @(posedge clk);
        #0.5;
        regs_cs = 1'b0;
        pal_cs  = 1'b0;
    endtask

    // palette write that keeps the local copy in step, byte by byte.
    task automatic pal_write(input logic [11:0] addr, input cps2_mix_pkg::reg16_t data,
                             input logic [1:0] dsn);
        cpu_write(1'b1, addr, data, dsn);
        if (!dsn[1]) begin
            pal_copy[addr][15:8] = data[15:8];
        end
        if (!dsn[0]) begin
            pal_copy[addr][7:0] = data[7:0];
        end
    endtask

    // one pixel per enable edge.
    // index shows one edge later on dut.mixed, color three edges later on rgb.
    task automatic pixel_edge(input vec_t v, input logic vld, input int row);
        int n;
        scr1   = v.s1;
        scr2   = v.s2;
        scr3   = v.s3;
        obj    = v.obj;
        obj_en = v.obj_en;
        wait_cen_edge();
        #0.5;
        hist_vld.push_back(vld);
        hist_idx.push_back(v.exp_idx);
        hist_row.push_back(row);
        n = hist_vld.size();
        if (n >= 2 && hist_vld[n-2]) begin
            check_idx(dut.mixed, hist_idx[n-2], $sformatf("row %0d index", hist_row[n-2]));
        end
        if (n == 4) begin
            if (hist_vld[0]) begin
                check_rgb(rgb, expect_rgb(pal_copy[hist_idx[0]]),
                          $sformatf("row %0d rgb", hist_row[0]));
            end
            void'(hist_vld.pop_front());
            void'(hist_idx.pop_front());
            void'(hist_row.pop_front());
        end
    endtask

    // idle pixels until everything in flight has been checked.
    task automatic drain();
        vec_t idle;
        idle    = '0;
        idle.s1 = t1;
        idle.s2 = t2;
        idle.s3 = t3;
        repeat (3) pixel_edge(idle, 1'b0, -1);
        hist_vld.delete();
        hist_idx.delete();
        hist_row.delete();
    endtask

    task automatic add_row(input cps2_mix_pkg::reg16_t lctl, input cps2_mix_pkg::reg16_t prio,
                           input logic [1:0] dsn, input cps2_mix_pkg::col_t s1,
                           input cps2_mix_pkg::col_t s2, input cps2_mix_pkg::col_t s3,
                           input cps2_mix_pkg::lyr_t oprio, input cps2_mix_pkg::col_t ocol,
                           input logic oen, input cps2_mix_pkg::lyr_t elyr,
                           input cps2_mix_pkg::col_t ecol);
        vec_t v;
        v = {lctl, prio, dsn, s1, s2, s3, oprio, ocol, oen, elyr, ecol};
        vecs.push_back(v);
    endtask

    // slots top to bottom 3,2,1 = 390e, 1,2,3 = 1b0e, 2,3,1 = 2d0e.
    // prio 5310 gives scroll priorities 1, 3, 5.
    task automatic load_table();
        // layer order, transparent tops fall through.
        add_row(16'h390e, 16'h5310, 2'b00, p1, p2, p3, 3'd0, op, 1'b0, 3'd3, p3);
        add_row(16'h390e, 16'h5310, 2'b00, p1, p2, t3, 3'd0, op, 1'b0, 3'd2, p2);
        add_row(16'h390e, 16'h5310, 2'b00, p1, t2, t3, 3'd0, op, 1'b0, 3'd1, p1);
        add_row(16'h390e, 16'h5310, 2'b00, t1, t2, t3, 3'd0, op, 1'b0, 3'd0, blank);
        // object over nothing wins at any priority.
        add_row(16'h390e, 16'h5310, 2'b00, t1, t2, t3, 3'd0, op, 1'b1, 3'd0, op);
        add_row(16'h390e, 16'h5310, 2'b00, t1, t2, t3, 3'd7, op, 1'b1, 3'd0, op);
        // object just above and just at each scroll priority.
        add_row(16'h390e, 16'h5310, 2'b00, p1, p2, p3, 3'd6, op, 1'b1, 3'd0, op);
        add_row(16'h390e, 16'h5310, 2'b00, p1, p2, p3, 3'd5, op, 1'b1, 3'd3, p3);
        add_row(16'h390e, 16'h5310, 2'b00, p1, p2, t3, 3'd4, op, 1'b1, 3'd0, op);
        add_row(16'h390e, 16'h5310, 2'b00, p1, p2, t3, 3'd3, op, 1'b1, 3'd2, p2);
        add_row(16'h390e, 16'h5310, 2'b00, p1, t2, t3, 3'd2, op, 1'b1, 3'd0, op);
        add_row(16'h390e, 16'h5310, 2'b00, p1, t2, t3, 3'd1, op, 1'b1, 3'd1, p1);
        // transparent or disabled object never shows.
        add_row(16'h390e, 16'h5310, 2'b00, p1, p2, p3, 3'd7, ot, 1'b1, 3'd3, p3);
        add_row(16'h390e, 16'h5310, 2'b00, p1, p2, p3, 3'd7, op, 1'b0, 3'd3, p3);
        add_row(16'h390e, 16'h5310, 2'b00, t1, t2, t3, 3'd7, ot, 1'b1, 3'd0, blank);
        add_row(16'h1b0e, 16'h5310, 2'b00, p1, p2, p3, 3'd0, op, 1'b0, 3'd1, p1);
        add_row(16'h1b0e, 16'h5310, 2'b00, t1, p2, p3, 3'd0, op, 1'b0, 3'd2, p2);
        add_row(16'h1b0e, 16'h5310, 2'b00, t1, t2, p3, 3'd0, op, 1'b0, 3'd3, p3);
        add_row(16'h2d0e, 16'h5310, 2'b00, p1, p2, p3, 3'd0, op, 1'b0, 3'd2, p2);
        add_row(16'h2d0e, 16'h5310, 2'b00, p1, t2, p3, 3'd0, op, 1'b0, 3'd3, p3);
        add_row(16'h2d0e, 16'h5310, 2'b00, p1, t2, t3, 3'd0, op, 1'b0, 3'd1, p1);
        // scroll 3 disabled.
        add_row(16'h3906, 16'h5310, 2'b00, p1, p2, p3, 3'd0, op, 1'b0, 3'd2, p2);
        add_row(16'h3906, 16'h5310, 2'b00, p1, t2, p3, 3'd0, op, 1'b0, 3'd1, p1);
        add_row(16'h3906, 16'h5310, 2'b00, t1, t2, p3, 3'd0, op, 1'b0, 3'd0, blank);
        // empty top slot, scroll 3 sits in no slot.
        add_row(16'h090e, 16'h5310, 2'b00, p1, p2, p3, 3'd0, op, 1'b0, 3'd2, p2);
        add_row(16'h090e, 16'h5310, 2'b00, p1, t2, p3, 3'd0, op, 1'b0, 3'd1, p1);
        add_row(16'h090e, 16'h5310, 2'b00, t1, t2, p3, 3'd0, op, 1'b0, 3'd0, blank);
        // low byte only, lyr_prio becomes 5377.
        add_row(16'h390e, 16'h7777, 2'b10, p1, t2, t3, 3'd7, op, 1'b1, 3'd1, p1);
        add_row(16'h390e, 16'h7777, 2'b10, p1, p2, t3, 3'd4, op, 1'b1, 3'd0, op);
        add_row(16'h390e, 16'h7777, 2'b10, p1, p2, p3, 3'd5, op, 1'b1, 3'd3, p3);
    endtask

    initial begin
        cps2_mix_pkg::reg16_t word;
        cps2_mix_pkg::reg16_t cur_lctl;
        cps2_mix_pkg::reg16_t cur_prio;
        logic [1:0]           cur_dsn;
        logic                 regs_set;
        vec_t                 v;
        clk      = 1'b0;
        rst      = 1'b1;
        pxl_cen  = 1'b0;
        regs_cs  = 1'b0;
        pal_cs   = 1'b0;
        wr       = '0;
        scr1     = t1;
        scr2     = t2;
        scr3     = t3;
        obj      = '0;
        obj_en   = 1'b0;
        lfsr     = 32'h5804a7b0;
        regs_set = 1'b0;
        cur_lctl = '0;
        cur_prio = '0;
        cur_dsn  = '0;
        load_table();
        repeat (16) @(posedge clk);
        #0.5;
        rst = 1'b0;
        check_rgb(rgb, '0, "rgb after reset");
        // random palette, with brightness 0 and 15 forced on two used entries.
        for (int a = 0; a < 4096; a++) begin
            rand_word(word);
            if (a == 'h00f) begin
                word[15:12] = 4'h0;
            end
            if (a == 'h763) begin
                word[15:12] = 4'hf;
            end
            pal_write(12'(a), word, 2'b00);
        end
        // upper byte only on the object pen.
        rand_word(word);
        pal_write(12'h05a, word, 2'b01);
        for (int r = 0; r < vecs.size(); r++) begin
            v = vecs[r];
            if (!regs_set || v.lctl != cur_lctl || v.prio != cur_prio
                    || v.prio_dsn != cur_dsn) begin
                if (regs_set) begin
                    drain();
                end
                cpu_write(1'b0, {9'd0, `CPS2_REG_LAYER}, v.lctl, 2'b00);
                cpu_write(1'b0, {9'd0, `CPS2_REG_PRIO}, v.prio, v.prio_dsn);
                cur_lctl = v.lctl;
                cur_prio = v.prio;
                cur_dsn  = v.prio_dsn;
                regs_set = 1'b1;
            end
            pixel_edge(v, 1'b1, r);
        end
        drain();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire
